// ==== design/isaPkg.sv ====
`default_nettype none

package isaPkg;

    // primary opcodes
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opSlti  = 6'h0a;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opXori  = 6'h0e;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // function codes, valid only under opRType
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluLui,
        aluNone
    } aluOpT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jTypeT;

    // same 32-bit word seen through each format
    typedef union packed {
        rTypeT r;
        iTypeT i;
        jTypeT j;
    } instrT;

    // sll r0, r0, 0
    localparam instrT nopWord = '0;

endpackage

`default_nettype wire

// ==== design/pipePkg.sv ====
`default_nettype none

package pipePkg;

    localparam int regAddrW = 5;
    localparam int dataW    = 32;

    typedef struct packed {
        logic               valid;
        logic [dataW-1:0]   pcPlus4;
        isaPkg::instrT      instr;
    } ifIdT;

    typedef struct packed {
        logic                valid;
        isaPkg::aluOpT       aluOp;
        logic                useImm;
        logic                useShamt;
        logic                memRead;
        logic                memWrite;
        logic                regWrite;
        logic [regAddrW-1:0] dest;
        logic [dataW-1:0]    rsVal;
        logic [dataW-1:0]    rtVal;
        logic [dataW-1:0]    imm;
        logic [4:0]          shamt;
        logic [dataW-1:0]    linkPc;
        // jal result is the link pc, not the ALU
        logic                isLink;
    } idExT;

    typedef struct packed {
        logic                valid;
        logic                memRead;
        logic                memWrite;
        logic                regWrite;
        logic [regAddrW-1:0] dest;
        logic [dataW-1:0]    aluResult;
        logic [dataW-1:0]    storeData;
    } exMemT;

    typedef struct packed {
        logic                regWrite;
        logic [regAddrW-1:0] dest;
        logic [dataW-1:0]    data;
    } memWbT;

    // wishbone classic master request
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [dataW-1:0] adr;
        logic [dataW-1:0] datOut;
    } wbMasterT;

endpackage

`default_nettype wire

// ==== design/fetchStage.sv ====
`default_nettype none

module fetchStage (
    input  wire                clk,
    input  wire                rstN,
    input  wire                freeze,
    input  wire                stall,
    input  wire                redirectValid,
    input  wire [31:0]         redirectTarget,
    input  wire isaPkg::instrT imemData,
    output logic [31:0]        imemAddr,
    output pipePkg::ifIdT      ifId
);

    logic [31:0] pc;

    assign imemAddr = pc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc         <= '0;
            ifId.valid <= 1'b0;
        end else if (!freeze) begin
            if (redirectValid) begin
                // word fetched behind the jump is dropped
                pc         <= redirectTarget;
                ifId.valid <= 1'b0;
                ifId.instr <= isaPkg::nopWord;
            end else if (!stall) begin
                pc           <= pc + 32'd4;
                ifId.valid   <= 1'b1;
                ifId.pcPlus4 <= pc + 32'd4;
                ifId.instr   <= imemData;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`default_nettype none

module regFile (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire [pipePkg::regAddrW-1:0]  rdAddrA,
    input  wire [pipePkg::regAddrW-1:0]  rdAddrB,
    input  wire pipePkg::memWbT          wb,
    output logic [pipePkg::dataW-1:0]    rdDataA,
    output logic [pipePkg::dataW-1:0]    rdDataB
);

    logic [pipePkg::dataW-1:0] regs [32];
    logic                      wrEn;

    // register 0 is never written
    assign wrEn = wb.regWrite && (wb.dest != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // same-cycle write shows up on the read ports
    assign rdDataA = (wrEn && wb.dest == rdAddrA) ? wb.data : regs[rdAddrA];
    assign rdDataB = (wrEn && wb.dest == rdAddrB) ? wb.data : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== design/decodeStage.sv ====
`default_nettype none

module decodeStage (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          freeze,
    input  wire pipePkg::ifIdT           ifId,
    input  wire pipePkg::memWbT          wb,
    input  wire [pipePkg::regAddrW-1:0]  exDest,
    input  wire                          exRegWrite,
    input  wire [pipePkg::regAddrW-1:0]  memDest,
    input  wire                          memRegWrite,
    output pipePkg::idExT                idEx,
    output logic                         stall,
    output logic                         redirectValid,
    output logic [31:0]                  redirectTarget
);

    isaPkg::instrT instr;
    logic [5:0]    op;
    logic [5:0]    fn;
    isaPkg::aluOpT aluOp;
    logic          isR;
    logic          isShift;
    logic          isJr;
    logic          isJal;
    logic          isJump;
    logic          isBranch;
    logic          zeroExt;
    logic          useImm;
    logic          regWrite;
    logic          usesRs;
    logic          usesRt;
    logic          takeBranch;
    logic          hazardRs;
    logic          hazardRt;
    logic [31:0]   rsVal;
    logic [31:0]   rtVal;
    logic [31:0]   immExt;
    logic [pipePkg::regAddrW-1:0] dest;

    assign instr = ifId.instr;
    assign op    = instr.r.opcode;
    assign fn    = instr.r.funct;

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (instr.r.rs),
        .rdAddrB (instr.r.rt),
        .wb      (wb),
        .rdDataA (rsVal),
        .rdDataB (rtVal)
    );

    assign isR      = op == isaPkg::opRType;
    assign isShift  = isR && (fn == isaPkg::fnSll || fn == isaPkg::fnSrl);
    assign isJr     = isR && fn == isaPkg::fnJr;
    assign isJal    = op == isaPkg::opJal;
    assign isJump   = op == isaPkg::opJ || isJal;
    assign isBranch = op == isaPkg::opBeq || op == isaPkg::opBne;
    assign zeroExt  = op inside {isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori};
    assign useImm   = zeroExt ||
                      op inside {isaPkg::opAddi, isaPkg::opSlti, isaPkg::opLui,
                                 isaPkg::opLw, isaPkg::opSw};

    always_comb begin
        aluOp = isaPkg::aluNone;
        if (isR) begin
            case (fn)
                isaPkg::fnAdd, isaPkg::fnAddu: aluOp = isaPkg::aluAdd;
                isaPkg::fnSub, isaPkg::fnSubu: aluOp = isaPkg::aluSub;
                isaPkg::fnAnd:                 aluOp = isaPkg::aluAnd;
                isaPkg::fnOr:                  aluOp = isaPkg::aluOr;
                isaPkg::fnXor:                 aluOp = isaPkg::aluXor;
                isaPkg::fnSlt:                 aluOp = isaPkg::aluSlt;
                isaPkg::fnSll:                 aluOp = isaPkg::aluSll;
                isaPkg::fnSrl:                 aluOp = isaPkg::aluSrl;
                default:                       aluOp = isaPkg::aluNone;
            endcase
        end else begin
            case (op)
                isaPkg::opAddi, isaPkg::opLw, isaPkg::opSw: aluOp = isaPkg::aluAdd;
                isaPkg::opAndi: aluOp = isaPkg::aluAnd;
                isaPkg::opOri:  aluOp = isaPkg::aluOr;
                isaPkg::opXori: aluOp = isaPkg::aluXor;
                isaPkg::opSlti: aluOp = isaPkg::aluSlt;
                isaPkg::opLui:  aluOp = isaPkg::aluLui;
                default:        aluOp = isaPkg::aluNone;
            endcase
        end
    end

    // jr and unknown functs leave aluOp at none and write nothing
    assign regWrite = (isR && aluOp != isaPkg::aluNone) || isJal ||
                      (useImm && op != isaPkg::opSw);
    assign dest     = isJal ? 5'd31 : (isR ? instr.r.rd : instr.i.rt);
    assign immExt   = zeroExt ? {16'd0, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};

    // which source registers this instruction actually reads
    assign usesRs = !(isShift || isJump || op == isaPkg::opLui);
    assign usesRt = (isR && !isJr) || isBranch || op == isaPkg::opSw;

    assign hazardRs = usesRs && instr.r.rs != '0 &&
                      ((exRegWrite && exDest == instr.r.rs) ||
                       (memRegWrite && memDest == instr.r.rs));
    assign hazardRt = usesRt && instr.r.rt != '0 &&
                      ((exRegWrite && exDest == instr.r.rt) ||
                       (memRegWrite && memDest == instr.r.rt));
    assign stall    = ifId.valid && (hazardRs || hazardRt);

    // branch resolves here, so no redirect before operands are final
    assign takeBranch    = (op == isaPkg::opBeq && rsVal == rtVal) ||
                           (op == isaPkg::opBne && rsVal != rtVal);
    assign redirectValid = ifId.valid && !stall && (isJump || isJr || takeBranch);

    always_comb begin
        if (isJr) begin
            redirectTarget = rsVal;
        end else if (isJump) begin
            redirectTarget = {ifId.pcPlus4[31:28], instr.j.target, 2'b00};
        end else begin
            redirectTarget = ifId.pcPlus4 + {immExt[29:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            idEx.valid <= 1'b0;
        end else if (!freeze) begin
            // stall sends a bubble downstream
            idEx.valid    <= ifId.valid && !stall;
            idEx.aluOp    <= aluOp;
            idEx.useImm   <= useImm;
            idEx.useShamt <= isShift;
            idEx.memRead  <= op == isaPkg::opLw;
            idEx.memWrite <= op == isaPkg::opSw;
            idEx.regWrite <= regWrite;
            idEx.dest     <= dest;
            idEx.rsVal    <= rsVal;
            idEx.rtVal    <= rtVal;
            idEx.imm      <= immExt;
            idEx.shamt    <= instr.r.shamt;
            idEx.linkPc   <= ifId.pcPlus4;
            idEx.isLink   <= isJal;
        end
    end

endmodule

`default_nettype wire

// ==== design/executeStage.sv ====
`default_nettype none

module executeStage (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          freeze,
    input  wire pipePkg::idExT           idEx,
    output pipePkg::exMemT               exMem,
    output logic [pipePkg::regAddrW-1:0] exDest,
    output logic                         exRegWrite
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluOut;
    logic [31:0] result;

    assign exDest     = idEx.dest;
    assign exRegWrite = idEx.valid && idEx.regWrite;

    // shifts take the amount on A and the value on B
    assign opA = idEx.useShamt ? {27'd0, idEx.shamt} : idEx.rsVal;
    assign opB = idEx.useImm ? idEx.imm : idEx.rtVal;

    always_comb begin
        case (idEx.aluOp)
            isaPkg::aluAdd: aluOut = opA + opB;
            isaPkg::aluSub: aluOut = opA - opB;
            isaPkg::aluAnd: aluOut = opA & opB;
            isaPkg::aluOr:  aluOut = opA | opB;
            isaPkg::aluXor: aluOut = opA ^ opB;
            isaPkg::aluSlt: aluOut = {31'd0, $signed(opA) < $signed(opB)};
            isaPkg::aluSll: aluOut = opB << opA[4:0];
            isaPkg::aluSrl: aluOut = opB >> opA[4:0];
            isaPkg::aluLui: aluOut = {opB[15:0], 16'd0};
            default:        aluOut = '0;
        endcase
    end

    assign result = idEx.isLink ? idEx.linkPc : aluOut;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exMem.valid <= 1'b0;
        end else if (!freeze) begin
            exMem.valid     <= idEx.valid;
            exMem.memRead   <= idEx.memRead;
            exMem.memWrite  <= idEx.memWrite;
            exMem.regWrite  <= idEx.regWrite;
            exMem.dest      <= idEx.dest;
            exMem.aluResult <= result;
            exMem.storeData <= idEx.rtVal;
        end
    end

endmodule

`default_nettype wire

// ==== design/memoryStage.sv ====
`default_nettype none

module memoryStage (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire pipePkg::exMemT          exMem,
    input  wire [31:0]                   wbDatIn,
    input  wire                          wbAck,
    output pipePkg::wbMasterT            wbOut,
    output logic                         freeze,
    output pipePkg::memWbT               wb,
    output logic [pipePkg::regAddrW-1:0] memDest,
    output logic                         memRegWrite
);

    logic memOp;
    logic gap;

    assign memOp       = exMem.valid && (exMem.memRead || exMem.memWrite);
    assign memDest     = exMem.dest;
    assign memRegWrite = exMem.valid && exMem.regWrite;

    // request stays put while frozen, so fields are stable until ack
    assign wbOut.cyc    = memOp && !gap;
    assign wbOut.stb    = memOp && !gap;
    assign wbOut.we     = exMem.memWrite;
    assign wbOut.adr    = exMem.aluResult;
    assign wbOut.datOut = exMem.storeData;

    // hold everything until the ack edge
    assign freeze = memOp && !(wbOut.stb && wbAck);

    // one idle cycle after every ack
    always_ff @(posedge clk) begin
        if (!rstN) begin
            gap <= 1'b0;
        end else begin
            gap <= wbOut.stb && wbAck;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wb.regWrite <= 1'b0;
        end else if (!freeze) begin
            wb.regWrite <= exMem.valid && exMem.regWrite;
            wb.dest     <= exMem.dest;
            wb.data     <= exMem.memRead ? wbDatIn : exMem.aluResult;
        end
    end

endmodule

`default_nettype wire

// ==== design/pipeCpuTop.sv ====
`default_nettype none

module pipeCpuTop (
    input  wire                clk,
    input  wire                rstN,
    input  wire isaPkg::instrT imemData,
    input  wire [31:0]         wbDatIn,
    input  wire                wbAck,
    output logic [31:0]        imemAddr,
    output pipePkg::wbMasterT  wbOut
);

    pipePkg::ifIdT  ifId;
    pipePkg::idExT  idEx;
    pipePkg::exMemT exMem;
    pipePkg::memWbT wb;
    logic           freeze;
    logic           stall;
    logic           redirectValid;
    logic [31:0]    redirectTarget;
    logic [pipePkg::regAddrW-1:0] exDest;
    logic [pipePkg::regAddrW-1:0] memDest;
    logic           exRegWrite;
    logic           memRegWrite;

    fetchStage fetch_i (
        .clk            (clk),
        .rstN           (rstN),
        .freeze         (freeze),
        .stall          (stall),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget),
        .imemData       (imemData),
        .imemAddr       (imemAddr),
        .ifId           (ifId)
    );

    decodeStage decode_i (
        .clk            (clk),
        .rstN           (rstN),
        .freeze         (freeze),
        .ifId           (ifId),
        .wb             (wb),
        .exDest         (exDest),
        .exRegWrite     (exRegWrite),
        .memDest        (memDest),
        .memRegWrite    (memRegWrite),
        .idEx           (idEx),
        .stall          (stall),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget)
    );

    executeStage execute_i (
        .clk        (clk),
        .rstN       (rstN),
        .freeze     (freeze),
        .idEx       (idEx),
        .exMem      (exMem),
        .exDest     (exDest),
        .exRegWrite (exRegWrite)
    );

    memoryStage memory_i (
        .clk         (clk),
        .rstN        (rstN),
        .exMem       (exMem),
        .wbDatIn     (wbDatIn),
        .wbAck       (wbAck),
        .wbOut       (wbOut),
        .freeze      (freeze),
        .wb          (wb),
        .memDest     (memDest),
        .memRegWrite (memRegWrite)
    );

endmodule

`default_nettype wire

// ==== tb/wbDataMem.sv ====
`default_nettype none

module wbDataMem (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire pipePkg::wbMasterT wbIn,
    output logic [31:0]            datOut,
    output logic                   ack
);

    logic [31:0] mem [256];
    logic [1:0]  waitLeft;
    logic        busy;
    logic [7:0]  idx;

    assign idx = wbIn.adr[9:2];

    // every word starts out unique
    initial begin
        ack    = 1'b0;
        datOut = '0;
        for (int k = 0; k < 256; k++) begin
            mem[k] = {16'hd00d, ~k[7:0], k[7:0]};
        end
    end

    always @(negedge clk) begin
        if (!rstN) begin
            ack  <= 1'b0;
            busy <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (wbIn.cyc && wbIn.stb && !ack) begin
                if (!busy) begin
                    // wait states for this access
                    waitLeft <= 2'($urandom % 4);
                    busy     <= 1'b1;
                end else if (waitLeft != 2'd0) begin
                    waitLeft <= waitLeft - 2'd1;
                end else begin
                    ack    <= 1'b1;
                    busy   <= 1'b0;
                    datOut <= mem[idx];
                    if (wbIn.we) begin
                        mem[idx] <= wbIn.datOut;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/pipeCpuTb.sv ====
`default_nettype none

module pipeCpuTb;

    localparam logic [31:0] doneAdr   = 32'h3fc;
    localparam logic [31:0] markerAdr = 32'h3f0;

    logic              clk = 1'b0;
    logic              rstN;
    isaPkg::instrT     imemData;
    logic [31:0]       imemAddr;
    logic [31:0]       wbDatIn;
    logic              wbAck;
    pipePkg::wbMasterT wbOut;
    logic              storeFire;

    logic [31:0] prog [256];
    logic [31:0] expAdr [64];
    logic [31:0] expDat [64];
    logic [31:0] slotAdr;
    logic        doneSeen = 1'b0;
    int          progLen = 0;
    int          expCount = 0;
    int          storeIdx = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    int          valueErrors = 0;
    int          protocolErrors = 0;
    int          timeoutErrors = 0;

    always #2 clk = ~clk;

    pipeCpuTop dut_i (
        .clk      (clk),
        .rstN     (rstN),
        .imemData (imemData),
        .wbDatIn  (wbDatIn),
        .wbAck    (wbAck),
        .imemAddr (imemAddr),
        .wbOut    (wbOut)
    );

    wbDataMem mem_i (
        .clk    (clk),
        .rstN   (rstN),
        .wbIn   (wbOut),
        .datOut (wbDatIn),
        .ack    (wbAck)
    );

    assign imemData  = prog[imemAddr[9:2]];
    assign storeFire = wbOut.cyc && wbOut.stb && wbOut.we && wbAck;

    function automatic logic [31:0] rWord(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sh,
                                          input logic [5:0] fn);
        return {isaPkg::opRType, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jWord(input logic [5:0] op, input logic [31:0] adr);
        return {op, adr[27:2]};
    endfunction

    task automatic putWord(input logic [31:0] w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic storeAt(input logic [4:0] rt, input logic [31:0] adr,
                           input logic [31:0] data);
        putWord(iWord(isaPkg::opSw, 5'd0, rt, adr[15:0]));
        expAdr[expCount] = adr;
        expDat[expCount] = data;
        expCount++;
    endtask

    task automatic storeReg(input logic [4:0] rt, input logic [31:0] data);
        storeAt(rt, slotAdr, data);
        slotAdr = slotAdr + 32'd4;
    endtask

    task automatic opThenStore(input logic [31:0] w, input logic [4:0] rd,
                               input logic [31:0] data);
        putWord(w);
        storeReg(rd, data);
    endtask

    // must be squashed, never stored
    task automatic putMarker();
        putWord(iWord(isaPkg::opSw, 5'd0, 5'd1, markerAdr[15:0]));
    endtask

    task automatic buildProgram();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        for (int k = 0; k < 256; k++) begin
            prog[k] = '0;
        end
        a       = 32'd7;
        b       = 32'hfffffffd;
        slotAdr = 32'h100;
        putWord(iWord(isaPkg::opAddi, 5'd0, 5'd1, 16'd7));
        putWord(iWord(isaPkg::opAddi, 5'd0, 5'd2, 16'hfffd));
        storeReg(5'd1, a);
        storeReg(5'd2, b);
        // every store right behind its producer
        opThenStore(rWord(5'd1, 5'd2, 5'd3, 5'd0, isaPkg::fnAdd), 5'd3, a + b);
        opThenStore(rWord(5'd1, 5'd2, 5'd4, 5'd0, isaPkg::fnAddu), 5'd4, a + b);
        opThenStore(rWord(5'd1, 5'd2, 5'd5, 5'd0, isaPkg::fnSub), 5'd5, a - b);
        opThenStore(rWord(5'd2, 5'd1, 5'd6, 5'd0, isaPkg::fnSubu), 5'd6, b - a);
        opThenStore(rWord(5'd1, 5'd2, 5'd7, 5'd0, isaPkg::fnAnd), 5'd7, a & b);
        opThenStore(rWord(5'd1, 5'd2, 5'd8, 5'd0, isaPkg::fnOr), 5'd8, a | b);
        opThenStore(rWord(5'd1, 5'd2, 5'd9, 5'd0, isaPkg::fnXor), 5'd9, a ^ b);
        opThenStore(rWord(5'd2, 5'd1, 5'd10, 5'd0, isaPkg::fnSlt), 5'd10,
                    ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        opThenStore(rWord(5'd1, 5'd2, 5'd11, 5'd0, isaPkg::fnSlt), 5'd11,
                    ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        opThenStore(rWord(5'd0, 5'd1, 5'd12, 5'd4, isaPkg::fnSll), 5'd12, a << 4);
        opThenStore(rWord(5'd0, 5'd2, 5'd13, 5'd28, isaPkg::fnSrl), 5'd13, b >> 28);
        opThenStore(iWord(isaPkg::opAndi, 5'd2, 5'd14, 16'hff00), 5'd14, b & 32'h0000ff00);
        opThenStore(iWord(isaPkg::opOri, 5'd0, 5'd15, 16'h8001), 5'd15, 32'h00008001);
        opThenStore(iWord(isaPkg::opXori, 5'd1, 5'd16, 16'hffff), 5'd16, a ^ 32'h0000ffff);
        opThenStore(iWord(isaPkg::opSlti, 5'd2, 5'd17, 16'd5), 5'd17,
                    ($signed(b) < 5) ? 32'd1 : 32'd0);
        opThenStore(iWord(isaPkg::opSlti, 5'd1, 5'd18, 16'hffff), 5'd18,
                    ($signed(a) < -1) ? 32'd1 : 32'd0);
        opThenStore(iWord(isaPkg::opLui, 5'd0, 5'd19, 16'habcd), 5'd19, 32'habcd0000);
        opThenStore(iWord(isaPkg::opAddi, 5'd1, 5'd20, 16'hfff6), 5'd20, a - 32'd10);
        // distances 1, 2 and 3 on r21
        putWord(iWord(isaPkg::opAddi, 5'd0, 5'd21, 16'd100));
        putWord(iWord(isaPkg::opAddi, 5'd21, 5'd22, 16'd1));
        putWord(rWord(5'd21, 5'd0, 5'd23, 5'd0, isaPkg::fnAdd));
        putWord(rWord(5'd21, 5'd22, 5'd24, 5'd0, isaPkg::fnAdd));
        putWord(rWord(5'd24, 5'd23, 5'd25, 5'd0, isaPkg::fnSub));
        storeReg(5'd22, 32'd101);
        storeReg(5'd23, 32'd100);
        storeReg(5'd24, 32'd201);
        storeReg(5'd25, 32'd101);
        // load then immediate use
        storeAt(5'd1, 32'h80, a);
        putWord(iWord(isaPkg::opLw, 5'd0, 5'd26, 16'h80));
        opThenStore(iWord(isaPkg::opAddi, 5'd26, 5'd27, 16'd1), 5'd27, a + 32'd1);
        storeAt(5'd2, 32'h84, b);
        putWord(iWord(isaPkg::opLw, 5'd0, 5'd28, 16'h84));
        storeReg(5'd28, b);
        // r0 stays zero
        putWord(iWord(isaPkg::opAddi, 5'd0, 5'd0, 16'd55));
        storeReg(5'd0, 32'd0);
        opThenStore(rWord(5'd1, 5'd1, 5'd0, 5'd0, isaPkg::fnAdd), 5'd0, 32'd0);
        // beq waits on r30 before it can resolve
        putWord(iWord(isaPkg::opAddi, 5'd0, 5'd30, 16'd7));
        putWord(iWord(isaPkg::opBeq, 5'd30, 5'd1, 16'd1));
        putMarker();
        putWord(iWord(isaPkg::opBne, 5'd1, 5'd1, 16'd1));
        storeReg(5'd1, a);
        putWord(iWord(isaPkg::opBne, 5'd1, 5'd2, 16'd1));
        putMarker();
        putWord(iWord(isaPkg::opBeq, 5'd1, 5'd2, 16'd1));
        storeReg(5'd2, b);
        pc = progLen * 4;
        putWord(jWord(isaPkg::opJ, pc + 32'd8));
        putMarker();
        pc = progLen * 4;
        putWord(jWord(isaPkg::opJal, pc + 32'd8));
        putMarker();
        storeReg(5'd31, pc + 32'd4);
        pc = progLen * 4;
        putWord(iWord(isaPkg::opAddi, 5'd0, 5'd29, 16'(pc + 32'd12)));
        putWord(rWord(5'd29, 5'd0, 5'd0, 5'd0, isaPkg::fnJr));
        putMarker();
        storeReg(5'd29, pc + 32'd12);
        // done store, then spin
        storeAt(5'd1, doneAdr, a);
        pc = progLen * 4;
        putWord(jWord(isaPkg::opJ, pc));
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (rstN && storeFire) begin
            storeIdx <= storeIdx + 1;
            if (wbOut.adr == doneAdr) begin
                doneSeen <= 1'b1;
            end
        end
    end

    storeAdrOk: assert property (@(posedge clk) disable iff (!rstN)
        storeFire |-> wbOut.adr == expAdr[storeIdx])
    else begin
        valueErrors++;
        $display("Fail %0t wbOut.adr expected %h observed %h", $time,
                 expAdr[$sampled(storeIdx)], $sampled(wbOut.adr));
    end

    storeDatOk: assert property (@(posedge clk) disable iff (!rstN)
        storeFire |-> wbOut.datOut == expDat[storeIdx])
    else begin
        valueErrors++;
        $display("Fail %0t wbOut.datOut expected %h observed %h", $time,
                 expDat[$sampled(storeIdx)], $sampled(wbOut.datOut));
    end

    // classic cycle held until the slave acks
    reqStable: assert property (@(posedge clk) disable iff (!rstN)
        (wbOut.stb && !wbAck) |=> (wbOut.cyc && wbOut.stb && $stable(wbOut.we) &&
                                   $stable(wbOut.adr) && $stable(wbOut.datOut)))
    else begin
        protocolErrors++;
        $display("Wishbone request dropped or changed before ack at %0t", $time);
    end

    resetBusIdle: assert property (@(posedge clk)
        (cycleCount >= 1 && (!rstN || $rose(rstN))) |-> (!wbOut.cyc && !wbOut.stb))
    else begin
        protocolErrors++;
        $display("Wishbone cycle active during or right after reset at %0t", $time);
    end

    resetPc: assert property (@(posedge clk)
        (cycleCount >= 1 && (!rstN || $rose(rstN))) |-> imemAddr == 32'd0)
    else begin
        valueErrors++;
        $display("Fail %0t imemAddr expected %h observed %h", $time,
                 32'd0, $sampled(imemAddr));
    end

    initial begin
        rstN = 1'b0;
        void'($urandom(32'h2b58));
        buildProgram();
        cycleLimit = 20 * progLen * 4;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        while (!doneSeen && cycleCount < cycleLimit) begin
            @(negedge clk);
        end
        if (!doneSeen) begin
            timeoutErrors++;
            $display("timeout: done store never seen");
        end
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 valueErrors, protocolErrors, timeoutErrors);
        if (valueErrors + protocolErrors + timeoutErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pipeCpuTop.f ====
design/isaPkg.sv
design/pipePkg.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/pipeCpuTop.sv
tb/wbDataMem.sv
tb/pipeCpuTb.sv
